// ==== Bender.yml ====
package:
  name: mram_domain

sources:
  - mram_pkg.sv
  - mram_cmd_fifo.sv
  - mram_write_packer.sv
  - mram_read_fetcher.sv
  - mram_port_arbiter.sv
  - mram_domain.sv
  - target: test
    files:
      - tb_mram_model.sv
      - tb_mram_domain.sv

// ==== mram_cmd_fifo.sv ====
/*
 * Small registered FIFO
 *  - FIFO_DEPTH entry circular buffer, read/write pointers and count
 *  - Payload type given by the type parameter T
 *  - Overflow check
 */
`timescale 1ns/1ps
module mram_cmd_fifo
    import mram_pkg::*;
#(
    parameter type T = mram_cmd_t
)
(
    input  logic mram_clk_i,
    input  logic rst_n_i,

    input  logic push_valid_i,
    output logic push_ready_o,
    input  T     push_data_i,

    output logic pop_valid_o,
    input  logic pop_ready_i,
    output T     pop_data_o
);

    T                      mem_q [FIFO_DEPTH];  // Entry storage
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;             // Entries held
    logic                  push_en;
    logic                  pop_en;

    // Wrap at the last entry so any depth works
    function automatic logic [FIFO_PTR_W-1:0] ptr_next(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != FIFO_CNT_W'(FIFO_DEPTH));  // Low when full
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];  // Head entry, registered

    assign push_en = push_valid_i & push_ready_o;
    assign pop_en  = pop_valid_o & pop_ready_i;

    always_ff @(posedge mram_clk_i)
    begin
        if (push_en)
            mem_q[wr_ptr_q] <= push_data_i;
    end

    always_ff @(posedge mram_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_en)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_en)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle or push and pop together
            endcase
        end
    end

    // Entry offered while full stays offered until taken
    a_no_overflow: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i))
        else $error("FIFO overflow");

endmodule

// ==== mram_domain.sv ====
/*
 * MRAM data path top level, single clock
 *  - Write and read command FIFOs
 *  - Write packer and read fetcher side by side
 *  - Port arbiter onto the memory port
 */
`timescale 1ns/1ps
module mram_domain
    import mram_pkg::*;
(
    input  logic                   mram_clk_i,
    input  logic                   rst_n_i,

    // Write commands and beats
    input  logic                   wr_cmd_valid_i,
    output logic                   wr_cmd_ready_o,
    input  logic [MRAM_ADDR_W-1:0] wr_cmd_addr_i,
    input  logic [MRAM_LEN_W-1:0]  wr_cmd_len_i,
    input  logic                   wr_data_valid_i,
    output logic                   wr_data_ready_o,
    input  logic [BEAT_W-1:0]      wr_data_i,

    // Read commands and returned words
    input  logic                   rd_cmd_valid_i,
    output logic                   rd_cmd_ready_o,
    input  logic [MRAM_ADDR_W-1:0] rd_cmd_addr_i,
    input  logic [MRAM_LEN_W-1:0]  rd_cmd_len_i,
    output logic                   rd_data_valid_o,
    input  logic                   rd_data_ready_i,
    output mram_word_t             rd_data_o,

    // Status
    output logic                   tx_busy_o,
    output logic                   tx_done_o,
    output logic                   rx_busy_o,

    // Memory port
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output logic [MRAM_ADDR_W-1:0] mem_addr_o,
    output mram_word_t             mem_wdata_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  mram_word_t             mem_rdata_i
);

    mram_cmd_t              wr_cmd;       // FIFO head, write side
    logic                   wr_cmd_valid;
    logic                   wr_cmd_ready;
    mram_cmd_t              rd_cmd;       // FIFO head, read side
    logic                   rd_cmd_valid;
    logic                   rd_cmd_ready;
    logic                   wr_req;
    logic [MRAM_ADDR_W-1:0] wr_addr;
    mram_word_t             wr_wdata;
    logic                   wr_gnt;
    logic                   rd_req;
    logic [MRAM_ADDR_W-1:0] rd_addr;
    logic                   rd_gnt;
    logic                   rd_rvalid;
    mram_word_t             rd_rdata;

    //////////////////////////////
    // Command FIFOs
    //////////////////////////////
    mram_cmd_fifo #(
        .T            ( mram_cmd_t                     )
    ) u_wr_cmd_fifo (
        .mram_clk_i   ( mram_clk_i                     ),
        .rst_n_i      ( rst_n_i                        ),
        .push_valid_i ( wr_cmd_valid_i                 ),
        .push_ready_o ( wr_cmd_ready_o                 ),
        .push_data_i  ( {wr_cmd_addr_i, wr_cmd_len_i}  ),  // Fields joined as addr, len
        .pop_valid_o  ( wr_cmd_valid                   ),
        .pop_ready_i  ( wr_cmd_ready                   ),
        .pop_data_o   ( wr_cmd                         )
    );

    mram_cmd_fifo #(
        .T            ( mram_cmd_t                     )
    ) u_rd_cmd_fifo (
        .mram_clk_i   ( mram_clk_i                     ),
        .rst_n_i      ( rst_n_i                        ),
        .push_valid_i ( rd_cmd_valid_i                 ),
        .push_ready_o ( rd_cmd_ready_o                 ),
        .push_data_i  ( {rd_cmd_addr_i, rd_cmd_len_i}  ),
        .pop_valid_o  ( rd_cmd_valid                   ),
        .pop_ready_i  ( rd_cmd_ready                   ),
        .pop_data_o   ( rd_cmd                         )
    );

    //////////////////////////////
    // Write and read paths
    //////////////////////////////
    mram_write_packer u_write_packer (
        .mram_clk_i      ( mram_clk_i      ),
        .rst_n_i         ( rst_n_i         ),
        .cmd_valid_i     ( wr_cmd_valid    ),
        .cmd_ready_o     ( wr_cmd_ready    ),
        .cmd_i           ( wr_cmd          ),
        .wr_data_valid_i ( wr_data_valid_i ),
        .wr_data_ready_o ( wr_data_ready_o ),
        .wr_data_i       ( wr_data_i       ),
        .req_o           ( wr_req          ),
        .addr_o          ( wr_addr         ),
        .wdata_o         ( wr_wdata        ),
        .gnt_i           ( wr_gnt          ),
        .tx_busy_o       ( tx_busy_o       ),
        .tx_done_o       ( tx_done_o       )
    );

    mram_read_fetcher u_read_fetcher (
        .mram_clk_i      ( mram_clk_i      ),
        .rst_n_i         ( rst_n_i         ),
        .cmd_valid_i     ( rd_cmd_valid    ),
        .cmd_ready_o     ( rd_cmd_ready    ),
        .cmd_i           ( rd_cmd          ),
        .req_o           ( rd_req          ),
        .addr_o          ( rd_addr         ),
        .gnt_i           ( rd_gnt          ),
        .rvalid_i        ( rd_rvalid       ),
        .rdata_i         ( rd_rdata        ),
        .rd_data_valid_o ( rd_data_valid_o ),
        .rd_data_ready_i ( rd_data_ready_i ),
        .rd_data_o       ( rd_data_o       ),
        .rx_busy_o       ( rx_busy_o       )
    );

    // Single memory port shared by both paths
    mram_port_arbiter u_port_arbiter (
        .mram_clk_i   ( mram_clk_i   ),
        .rst_n_i      ( rst_n_i      ),
        .wr_req_i     ( wr_req       ),
        .wr_addr_i    ( wr_addr      ),
        .wr_wdata_i   ( wr_wdata     ),
        .wr_gnt_o     ( wr_gnt       ),
        .rd_req_i     ( rd_req       ),
        .rd_addr_i    ( rd_addr      ),
        .rd_gnt_o     ( rd_gnt       ),
        .rd_rvalid_o  ( rd_rvalid    ),
        .rd_rdata_o   ( rd_rdata     ),
        .mem_req_o    ( mem_req_o    ),
        .mem_we_o     ( mem_we_o     ),
        .mem_addr_o   ( mem_addr_o   ),
        .mem_wdata_o  ( mem_wdata_o  ),
        .mem_gnt_i    ( mem_gnt_i    ),
        .mem_rvalid_i ( mem_rvalid_i ),
        .mem_rdata_i  ( mem_rdata_i  )
    );

endmodule

// ==== mram_pkg.sv ====
/*
 * Shared definitions of the MRAM data path
 *  - Address, length, beat and word widths
 *  - Depth and pointer widths of the small FIFOs
 *  - Command and memory word types
 */
package mram_pkg;

    localparam int MRAM_ADDR_W = 16;  // 64-bit word address
    localparam int MRAM_LEN_W  = 8;   // Length in words, 1 to 255
    localparam int BEAT_W      = 32;  // Write beat
    localparam int WORD_W      = 64;  // Memory word

    //////////////////////////////
    // FIFO sizing
    //////////////////////////////
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH

    //////////////////////////////
    // Payload types
    //////////////////////////////
    typedef struct packed {
        logic [MRAM_ADDR_W-1:0] addr;  // Start word address
        logic [MRAM_LEN_W-1:0]  len;   // Words to transfer
    } mram_cmd_t;

    typedef logic [WORD_W-1:0] mram_word_t;

endpackage

// ==== mram_port_arbiter.sv ====
/*
 * Memory port arbiter
 *  - Alternating priority between write and read paths
 *  - Choice held while the memory stalls a request
 *  - Read returns routed to the read path
 */
`timescale 1ns/1ps
module mram_port_arbiter
    import mram_pkg::*;
(
    input  logic                   mram_clk_i,
    input  logic                   rst_n_i,

    input  logic                   wr_req_i,
    input  logic [MRAM_ADDR_W-1:0] wr_addr_i,
    input  mram_word_t             wr_wdata_i,
    output logic                   wr_gnt_o,

    input  logic                   rd_req_i,
    input  logic [MRAM_ADDR_W-1:0] rd_addr_i,
    output logic                   rd_gnt_o,
    output logic                   rd_rvalid_o,
    output mram_word_t             rd_rdata_o,

    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output logic [MRAM_ADDR_W-1:0] mem_addr_o,
    output mram_word_t             mem_wdata_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  mram_word_t             mem_rdata_i
);

    logic last_wr_q;  // Write path served last
    logic hold_q;     // Stalled request pending
    logic hold_wr_q;  // Path of the stalled request
    logic sel_wr;

    // Write wins if alone, or if the read path went last
    assign sel_wr = hold_q ? hold_wr_q : (wr_req_i && (!rd_req_i || !last_wr_q));

    assign mem_req_o   = wr_req_i | rd_req_i;
    assign mem_we_o    = sel_wr;
    assign mem_addr_o  = sel_wr ? wr_addr_i : rd_addr_i;
    assign mem_wdata_o = wr_wdata_i;

    assign wr_gnt_o    = mem_gnt_i & sel_wr;
    assign rd_gnt_o    = mem_gnt_i & rd_req_i & !sel_wr;
    assign rd_rvalid_o = mem_rvalid_i;
    assign rd_rdata_o  = mem_rdata_i;

    always_ff @(posedge mram_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            last_wr_q <= 1'b0;
            hold_q    <= 1'b0;
            hold_wr_q <= 1'b0;
        end
        else
        begin
            if (mem_req_o && mem_gnt_i)
                last_wr_q <= sel_wr;
            hold_q    <= mem_req_o & !mem_gnt_i;  // Freeze choice across a stall
            hold_wr_q <= sel_wr;
        end
    end

    // Each memory grant lands on exactly one requesting path
    a_one_gnt: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        mem_req_o && mem_gnt_i |-> (wr_gnt_o && wr_req_i) != (rd_gnt_o && rd_req_i))
        else $error("Memory grant not routed to exactly one requesting path");

endmodule

// ==== mram_read_fetcher.sv ====
/*
 * Read path
 *  - Pops a read command and issues reads at consecutive addresses
 *  - Credit limit keeps in-flight plus buffered words within FIFO_DEPTH
 *  - Return buffer feeds the valid/ready output stream
 */
`timescale 1ns/1ps
module mram_read_fetcher
    import mram_pkg::*;
(
    input  logic                   mram_clk_i,
    input  logic                   rst_n_i,

    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    input  mram_cmd_t              cmd_i,

    output logic                   req_o,
    output logic [MRAM_ADDR_W-1:0] addr_o,
    input  logic                   gnt_i,
    input  logic                   rvalid_i,
    input  mram_word_t             rdata_i,

    output logic                   rd_data_valid_o,
    input  logic                   rd_data_ready_i,
    output mram_word_t             rd_data_o,

    output logic                   rx_busy_o
);

    logic [MRAM_LEN_W-1:0]  issue_cnt_q;    // Requests still to issue
    logic [MRAM_LEN_W-1:0]  deliver_cnt_q;  // Words still to hand out
    logic [FIFO_CNT_W-1:0]  inflight_q;     // Granted, data not back yet
    logic [FIFO_CNT_W-1:0]  credit_q;       // In flight plus buffered
    logic [MRAM_ADDR_W-1:0] addr_q;
    logic                   cmd_en;
    logic                   issue_en;
    logic                   deliver_en;
    logic                   buf_push_ready;

    assign cmd_ready_o = (deliver_cnt_q == '0);  // Previous command fully drained
    assign rx_busy_o   = (deliver_cnt_q != '0);
    assign req_o       = (issue_cnt_q != '0) && (credit_q < FIFO_CNT_W'(FIFO_DEPTH));
    assign addr_o      = addr_q;

    assign cmd_en     = cmd_valid_i & cmd_ready_o;
    assign issue_en   = req_o & gnt_i;
    assign deliver_en = rd_data_valid_o & rd_data_ready_i;

    always_ff @(posedge mram_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            issue_cnt_q   <= '0;
            deliver_cnt_q <= '0;
            inflight_q    <= '0;
            credit_q      <= '0;
        end
        else
        begin
            if (cmd_en)
            begin
                issue_cnt_q   <= cmd_i.len;
                deliver_cnt_q <= cmd_i.len;
            end
            else
            begin
                if (issue_en)
                    issue_cnt_q <= issue_cnt_q - 1'b1;
                if (deliver_en)
                    deliver_cnt_q <= deliver_cnt_q - 1'b1;
            end
            case ({issue_en, rvalid_i})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
            case ({issue_en, deliver_en})
                2'b10:   credit_q <= credit_q + 1'b1;  // Slot reserved at grant
                2'b01:   credit_q <= credit_q - 1'b1;  // Slot freed at output
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge mram_clk_i)
    begin
        if (cmd_en)
            addr_q <= cmd_i.addr;
        else if (issue_en)
            addr_q <= addr_q + 1'b1;
    end

    // Return buffer, space guaranteed by the credit count
    mram_cmd_fifo #(
        .T            ( mram_word_t     )
    ) u_rdata_buf (
        .mram_clk_i   ( mram_clk_i      ),
        .rst_n_i      ( rst_n_i         ),
        .push_valid_i ( rvalid_i        ),
        .push_ready_o ( buf_push_ready  ),
        .push_data_i  ( rdata_i         ),
        .pop_valid_o  ( rd_data_valid_o ),
        .pop_ready_i  ( rd_data_ready_i ),
        .pop_data_o   ( rd_data_o       )
    );

    a_len_nonzero: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        cmd_en |-> (cmd_i.len != '0))
        else $error("Read command with zero length");

    // Returned word matches an outstanding read and finds room
    a_rvalid_expected: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        rvalid_i |-> (inflight_q != '0) && buf_push_ready)
        else $error("Read data returned with no read in flight");

endmodule

// ==== mram_write_packer.sv ====
/*
 * Write path
 *  - Pops a write command, packs beat pairs into 64-bit words
 *  - Issues one req/gnt write per word at consecutive addresses
 *  - Busy flag and end of command pulse
 */
`timescale 1ns/1ps
module mram_write_packer
    import mram_pkg::*;
(
    input  logic                   mram_clk_i,
    input  logic                   rst_n_i,

    input  logic                   cmd_valid_i,
    output logic                   cmd_ready_o,
    input  mram_cmd_t              cmd_i,

    input  logic                   wr_data_valid_i,
    output logic                   wr_data_ready_o,
    input  logic [BEAT_W-1:0]      wr_data_i,

    output logic                   req_o,
    output logic [MRAM_ADDR_W-1:0] addr_o,
    output mram_word_t             wdata_o,
    input  logic                   gnt_i,

    output logic                   tx_busy_o,
    output logic                   tx_done_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_REQ} state_e;

    state_e                 state_q;
    logic [MRAM_LEN_W-1:0]  cnt_q;    // Words left
    logic                   hi_q;     // Next beat is the high half
    logic                   done_q;
    logic [BEAT_W-1:0]      low_q;    // Low half of the pair
    logic [MRAM_ADDR_W-1:0] addr_q;
    mram_word_t             word_q;   // Packed word under request
    logic                   cmd_en;
    logic                   beat_en;
    logic                   gnt_en;

    assign cmd_ready_o     = (state_q == ST_IDLE);
    assign wr_data_ready_o = (state_q == ST_FILL);  // Stalls while a word waits
    assign req_o           = (state_q == ST_REQ);
    assign addr_o          = addr_q;
    assign wdata_o         = word_q;
    assign tx_busy_o       = (state_q != ST_IDLE);
    assign tx_done_o       = done_q;

    assign cmd_en  = cmd_valid_i & cmd_ready_o;
    assign beat_en = wr_data_valid_i & wr_data_ready_o;
    assign gnt_en  = req_o & gnt_i;

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge mram_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            hi_q    <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE:
                    if (cmd_en)
                    begin
                        cnt_q   <= cmd_i.len;
                        state_q <= ST_FILL;
                    end
                ST_FILL:
                    if (beat_en)
                    begin
                        hi_q <= ~hi_q;
                        if (hi_q)
                            state_q <= ST_REQ;  // Pair complete
                    end
                default:
                    if (gnt_en)
                    begin
                        cnt_q <= cnt_q - 1'b1;
                        if (cnt_q == MRAM_LEN_W'(1))
                        begin
                            done_q  <= 1'b1;   // Last word granted
                            state_q <= ST_IDLE;
                        end
                        else
                            state_q <= ST_FILL;
                    end
            endcase
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////
    always_ff @(posedge mram_clk_i)
    begin
        if (cmd_en)
            addr_q <= cmd_i.addr;
        else if (gnt_en)
            addr_q <= addr_q + 1'b1;  // Next word address
        if (beat_en && !hi_q)
            low_q <= wr_data_i;
        if (beat_en && hi_q)
            word_q <= {wr_data_i, low_q};  // Second beat is the high half
    end

    a_len_nonzero: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        cmd_en |-> (cmd_i.len != '0))
        else $error("Write command with zero length");

    // Request and payload held until granted
    a_req_stable: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(wdata_o))
        else $error("Write request changed before grant");

endmodule

// ==== tb.f ====
mram_pkg.sv
mram_cmd_fifo.sv
mram_write_packer.sv
mram_read_fetcher.sv
mram_port_arbiter.sv
mram_domain.sv
tb_mram_model.sv
tb_mram_domain.sv

// ==== tb_mram_domain.sv ====
/*
 * Testbench of the MRAM data path
 *  - Clock, reset, command and beat stimulus
 *  - Shadow memory as scoreboard
 *  - Protocol assertions and transfer counters
 */
`timescale 1ns/1ps
module tb_mram_domain
    import mram_pkg::*;
;

    localparam int CLK_PER = 20;
    localparam int DRV_DLY = 1;    // Drive after the rising edge
    localparam int LIMIT   = 400;  // Cycles per wait

    logic                   mram_clk_i;
    logic                   rst_n_i;
    logic                   wr_cmd_valid_i, wr_cmd_ready_o;
    logic [MRAM_ADDR_W-1:0] wr_cmd_addr_i;
    logic [MRAM_LEN_W-1:0]  wr_cmd_len_i;
    logic                   wr_data_valid_i, wr_data_ready_o;
    logic [BEAT_W-1:0]      wr_data_i;
    logic                   rd_cmd_valid_i, rd_cmd_ready_o;
    logic [MRAM_ADDR_W-1:0] rd_cmd_addr_i;
    logic [MRAM_LEN_W-1:0]  rd_cmd_len_i;
    logic                   rd_data_valid_o, rd_data_ready_i;
    mram_word_t             rd_data_o;
    logic                   tx_busy_o, tx_done_o, rx_busy_o;
    logic                   mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
    logic [MRAM_ADDR_W-1:0] mem_addr_o;
    mram_word_t             mem_wdata_o, mem_rdata_i;

    mram_word_t shadow [logic [MRAM_ADDR_W-1:0]];  // Expected memory contents
    int         errors, sva_errors;
    int         done_pulses, we_xfers, rd_xfers;     // Monitor counts
    int         wr_cmds, wr_words, rd_words;         // Stimulus counts

    mram_domain uut (.*);

    tb_mram_model u_model (
        .mram_clk_i   ( mram_clk_i   ),
        .rst_n_i      ( rst_n_i      ),
        .mem_req_i    ( mem_req_o    ),
        .mem_we_i     ( mem_we_o     ),
        .mem_addr_i   ( mem_addr_o   ),
        .mem_wdata_i  ( mem_wdata_o  ),
        .mem_gnt_o    ( mem_gnt_i    ),
        .mem_rvalid_o ( mem_rvalid_i ),
        .mem_rdata_o  ( mem_rdata_i  )
    );

    initial
    begin
        mram_clk_i = 1'b0;
        forever #(CLK_PER/2) mram_clk_i = ~mram_clk_i;
    end

    //////////////////////////////
    // Protocol assertions
    //////////////////////////////
    a_reset_quiet: assert property (@(posedge mram_clk_i)
        !rst_n_i |-> !mem_req_o && !rd_data_valid_o && !tx_busy_o && !tx_done_o && !rx_busy_o)
        else begin sva_errors++; $display("Outputs not low during reset"); end

    a_done_after_busy: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        tx_done_o |-> $past(tx_busy_o))
        else begin sva_errors++; $display("Write done pulse without busy before it"); end

    a_done_single: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        tx_done_o |=> !tx_done_o)
        else begin sva_errors++; $display("Write done pulse longer than one cycle"); end

    // Output word held under back-pressure
    a_rd_hold: assert property (@(posedge mram_clk_i) disable iff (!rst_n_i)
        rd_data_valid_o && !rd_data_ready_i |=> rd_data_valid_o && $stable(rd_data_o))
        else begin sva_errors++; $display("Read word dropped or changed while stalled"); end

    always @(negedge mram_clk_i)  // Stable mid-cycle sampling
    begin
        if (rst_n_i)
        begin
            if (tx_done_o)
                done_pulses++;
            if (mem_req_o && mem_gnt_i && mem_we_o)
                we_xfers++;
            if (mem_req_o && mem_gnt_i && !mem_we_o)
                rd_xfers++;
        end
    end

    //////////////////////////////
    // Helper tasks
    //////////////////////////////
    task automatic next_cycle();
        @(posedge mram_clk_i);
        #DRV_DLY;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check_word(input string name, input mram_word_t exp, input mram_word_t act);
        assert (act === exp)
        else begin errors++; $display("Fail %s expected %h actual %h", name, exp, act); end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        assert (act == exp)
        else begin errors++; $display("Fail %s expected %0d actual %0d", name, exp, act); end
    endtask

    task automatic push_wr_cmd(input logic [MRAM_ADDR_W-1:0] addr, input int len);
        int t;
        t = 0;
        wr_cmd_addr_i  = addr;
        wr_cmd_len_i   = MRAM_LEN_W'(len);
        wr_cmd_valid_i = 1'b1;
        @(negedge mram_clk_i);
        while (!wr_cmd_ready_o)
        begin
            t++;
            if (t > LIMIT)
                abort_on_timeout("write command ready");
            @(negedge mram_clk_i);
        end
        next_cycle();
        wr_cmd_valid_i = 1'b0;
    endtask

    task automatic push_rd_cmd(input logic [MRAM_ADDR_W-1:0] addr, input int len);
        int t;
        t = 0;
        rd_cmd_addr_i  = addr;
        rd_cmd_len_i   = MRAM_LEN_W'(len);
        rd_cmd_valid_i = 1'b1;
        @(negedge mram_clk_i);
        while (!rd_cmd_ready_o)
        begin
            t++;
            if (t > LIMIT)
                abort_on_timeout("read command ready");
            @(negedge mram_clk_i);
        end
        next_cycle();
        rd_cmd_valid_i = 1'b0;
    endtask

    task automatic send_beat(input logic [BEAT_W-1:0] beat);
        int t;
        t = 0;
        wr_data_i       = beat;
        wr_data_valid_i = 1'b1;
        @(negedge mram_clk_i);
        while (!wr_data_ready_o)
        begin
            t++;
            if (t > LIMIT)
                abort_on_timeout("write beat ready");
            @(negedge mram_clk_i);
        end
        next_cycle();
        wr_data_valid_i = 1'b0;
    endtask

    // Command, beat pairs, then the end of command pulse
    task automatic write_burst(input logic [MRAM_ADDR_W-1:0] addr, input int len);
        logic [BEAT_W-1:0] lo;
        logic [BEAT_W-1:0] hi;
        int                t;
        push_wr_cmd(addr, len);
        for (int n = 0; n < len; n++)
        begin
            lo = $urandom;
            hi = $urandom;
            send_beat(lo);
            send_beat(hi);
            shadow[addr + MRAM_ADDR_W'(n)] = {hi, lo};  // Second beat is the high half
        end
        wr_cmds++;
        wr_words += len;
        t = 0;
        @(negedge mram_clk_i);
        while (!tx_done_o)
        begin
            t++;
            if (t > LIMIT)
                abort_on_timeout("write done pulse");
            @(negedge mram_clk_i);
        end
        next_cycle();
    endtask

    task automatic read_burst(input string name, input logic [MRAM_ADDR_W-1:0] addr,
                              input int len, input bit rand_ready);
        int k;
        int t;
        k = 0;
        t = 0;
        push_rd_cmd(addr, len);
        while (k < len)
        begin
            rd_data_ready_i = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            @(negedge mram_clk_i);
            if (rd_data_valid_o && rd_data_ready_i)
            begin
                check_word(name, shadow[addr + MRAM_ADDR_W'(k)], rd_data_o);
                assert (rx_busy_o)
                else begin errors++; $display("Read busy low before the last word"); end
                k++;
                t = 0;
            end
            else
            begin
                t++;
                if (t > LIMIT)
                    abort_on_timeout("read data");
            end
            next_cycle();
        end
        rd_data_ready_i = 1'b0;
        rd_words += len;
        t = 0;
        @(negedge mram_clk_i);
        while (rx_busy_o)  // Falls after the last word
        begin
            t++;
            if (t > LIMIT)
                abort_on_timeout("read busy to fall");
            @(negedge mram_clk_i);
        end
        next_cycle();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        logic [MRAM_ADDR_W-1:0] base;
        void'($urandom(32'h18a7));
        rst_n_i         = 1'b0;
        wr_cmd_valid_i  = 1'b0;
        wr_cmd_addr_i   = '0;
        wr_cmd_len_i    = '0;
        wr_data_valid_i = 1'b0;
        wr_data_i       = '0;
        rd_cmd_valid_i  = 1'b0;
        rd_cmd_addr_i   = '0;
        rd_cmd_len_i    = '0;
        rd_data_ready_i = 1'b0;
        repeat (16) @(posedge mram_clk_i);
        #DRV_DLY;
        rst_n_i = 1'b1;

        // Quiet outputs and ready command inputs right after reset
        @(negedge mram_clk_i);
        assert (!mem_req_o && !rd_data_valid_o && !tx_busy_o && !tx_done_o && !rx_busy_o)
        else begin errors++; $display("Outputs not low after reset"); end
        assert (wr_cmd_ready_o && rd_cmd_ready_o)
        else begin errors++; $display("Command ready low after reset"); end
        next_cycle();

        write_burst(16'h0010, 1);  // Single word round trip
        read_burst("single", 16'h0010, 1, 1'b0);

        base = 16'h0100;  // Bursts at increasing addresses
        write_burst(base, 2);
        write_burst(base + 16'd2, 3);
        write_burst(base + 16'd5, 5);
        write_burst(base + 16'd10, 8);
        read_burst("burst_len2", base, 2, 1'b0);
        read_burst("burst_len3", base + 16'd2, 3, 1'b0);
        read_burst("burst_len5", base + 16'd5, 5, 1'b0);
        read_burst("burst_len8", base + 16'd10, 8, 1'b0);

        write_burst(16'h0400, 20);  // Back-pressure on the output stream
        read_burst("backpressure", 16'h0400, 20, 1'b1);

        fork  // Both paths on the port at once
            write_burst(16'h0800, 6);
            read_burst("concurrent", base, 18, 1'b1);
        join
        read_burst("concurrent_wr", 16'h0800, 6, 1'b0);

        check_count("done_pulses", wr_cmds, done_pulses);
        check_count("write_xfers", wr_words, we_xfers);
        check_count("read_xfers", rd_words, rd_xfers);

        $display("Errors: %0d checks, %0d assertions", errors, sva_errors);
        if (errors == 0 && sva_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tb_mram_model.sv ====
/*
 * Behavioral memory for the MRAM memory port
 *  - Word array filled with an address pattern
 *  - Random grant stalls
 *  - Read data one cycle after a granted read
 */
`timescale 1ns/1ps
module tb_mram_model
    import mram_pkg::*;
(
    input  logic                   mram_clk_i,
    input  logic                   rst_n_i,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  logic [MRAM_ADDR_W-1:0] mem_addr_i,
    input  mram_word_t             mem_wdata_i,
    output logic                   mem_gnt_o,
    output logic                   mem_rvalid_o,
    output mram_word_t             mem_rdata_o
);

    mram_word_t mem [0:(1 << MRAM_ADDR_W)-1];
    logic       gnt_roll_q;  // Grant allowed this cycle

    initial
    begin
        for (int a = 0; a < (1 << MRAM_ADDR_W); a++)
            mem[a] = {16'hc0de, 16'(a), ~16'(a), 16'(a)};  // Whole address in the pattern
    end

    assign mem_gnt_o = mem_req_i & gnt_roll_q;

    always @(posedge mram_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            gnt_roll_q   <= 1'b0;
            mem_rvalid_o <= 1'b0;
        end
        else
        begin
            gnt_roll_q   <= ($urandom % 4) != 0;  // Roughly one stall in four
            mem_rvalid_o <= mem_req_i & mem_gnt_o & ~mem_we_i;
        end
    end

    always @(posedge mram_clk_i)
    begin
        if (mem_req_i && mem_gnt_o)
        begin
            if (mem_we_i)
                mem[mem_addr_i] <= mem_wdata_i;
            else
                mem_rdata_o <= mem[mem_addr_i];
        end
    end

endmodule
